//--- logic/udp_ep_pkg.sv
// Shared widths, protocol constants and receive buffer sizing for the UDP endpoint logic
package udp_ep_pkg;

  // Header field types
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] udp_len_t;
  typedef logic [7:0]  ip_proto_t;

  // Payload data
  typedef logic [7:0]  byte_t;

  // UDP header size in bytes
  localparam udp_len_t UDP_HDR_BYTES = 16'd8;

  // IP protocol number of UDP
  localparam ip_proto_t IP_PROTO_UDP = 8'd17;

  // Receive buffer size, power of two
  localparam int RX_BUF_DEPTH = 16;
  localparam int RX_BUF_AW    = $clog2(RX_BUF_DEPTH);

  // Receive filter states
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_FORWARD,
    RX_DROP
  } rx_state_t;

endpackage

//--- logic/udp_byte_stream_if.sv
// Byte stream from the receive filter into the payload buffer, valid/ready with tlast
interface udp_byte_stream_if
  import udp_ep_pkg::*;
();

  byte_t tdata;
  logic  tvalid;
  logic  tready;
  logic  tlast;

  // Producer side, the filter
  modport src (
    output tdata,
    output tvalid,
    output tlast,
    input  tready
  );

  // Consumer side, the buffer
  modport sink (
    input  tdata,
    input  tvalid,
    input  tlast,
    output tready
  );

endinterface

//--- logic/udp_rx_filter.sv
// Accepts or drops each received UDP frame, latches its header and raises the receive interrupt
module udp_rx_filter
  import udp_ep_pkg::*;
(
  input  logic      clk_axi,
  input  logic      rst_axi,
  input  logic      i_hdr_valid,
  input  mac_addr_t i_src_mac,
  input  ip_addr_t  i_src_ip,
  input  ip_proto_t i_protocol,
  input  udp_port_t i_src_port,
  input  udp_port_t i_dst_port,
  input  udp_len_t  i_udp_length,
  input  logic      i_filter_en,
  input  udp_port_t i_filter_port,
  input  ip_addr_t  i_filter_ip,
  input  byte_t     i_pl_tdata,
  input  logic      i_pl_tvalid,
  input  logic      i_pl_tlast,
  output logic      o_pl_tready,
  udp_byte_stream_if.src out_stream,
  input  logic      i_clear_irq,
  output mac_addr_t o_recv_mac,
  output ip_addr_t  o_recv_ip,
  output udp_port_t o_recv_src_port,
  output udp_port_t o_recv_dst_port,
  output udp_len_t  o_recv_length,
  output logic      o_pkt_recv
);

  rx_state_t state;
  logic      hdr_match;
  logic      accept;
  logic      pl_xfer_last;
  logic      fwd_last;

  // Filter disabled lets everything through
  assign hdr_match = (i_protocol == IP_PROTO_UDP) && (i_dst_port == i_filter_port) &&
                     (i_src_ip == i_filter_ip);
  assign accept    = !i_filter_en || hdr_match;

  // Payload only moves to the buffer while forwarding
  assign out_stream.tdata  = i_pl_tdata;
  assign out_stream.tvalid = i_pl_tvalid && (state == RX_FORWARD);
  assign out_stream.tlast  = i_pl_tlast;

  always_comb begin
    case (state)
      RX_FORWARD: o_pl_tready = out_stream.tready;
      RX_DROP:    o_pl_tready = 1'b1;
      default:    o_pl_tready = 1'b0;
    endcase
  end

  assign pl_xfer_last = i_pl_tvalid && o_pl_tready && i_pl_tlast;
  assign fwd_last     = out_stream.tvalid && out_stream.tready && out_stream.tlast;

  always_ff @(posedge clk_axi) begin
    if (rst_axi) begin
      state <= RX_IDLE;
    end else begin
      case (state)
        RX_IDLE: begin
          if (i_hdr_valid) begin
            state <= accept ? RX_FORWARD : RX_DROP;
          end
        end
        RX_FORWARD, RX_DROP: begin
          if (pl_xfer_last) begin
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Header of the last accepted frame
  always_ff @(posedge clk_axi) begin
    if (rst_axi) begin
      o_recv_mac      <= '0;
      o_recv_ip       <= '0;
      o_recv_src_port <= '0;
      o_recv_dst_port <= '0;
      o_recv_length   <= '0;
    end else if ((state == RX_IDLE) && i_hdr_valid && accept) begin
      o_recv_mac      <= i_src_mac;
      o_recv_ip       <= i_src_ip;
      o_recv_src_port <= i_src_port;
      o_recv_dst_port <= i_dst_port;
      // Payload bytes only
      o_recv_length   <= i_udp_length - UDP_HDR_BYTES;
    end
  end

  // Clear beats a new frame in the same cycle
  always_ff @(posedge clk_axi) begin
    if (rst_axi) begin
      o_pkt_recv <= 1'b0;
    end else if (i_clear_irq) begin
      o_pkt_recv <= 1'b0;
    end else if (fwd_last) begin
      o_pkt_recv <= 1'b1;
    end
  end

  // Stack must not start a new header mid frame
  a_hdr_only_idle: assert property (
    @(posedge clk_axi) disable iff (rst_axi)
    i_hdr_valid |-> (state == RX_IDLE)
  );

  // No payload before its header
  a_no_payload_idle: assert property (
    @(posedge clk_axi) disable iff (rst_axi)
    (state == RX_IDLE) |-> !i_pl_tvalid
  );

endmodule

//--- logic/rx_payload_buffer.sv
// Circular byte buffer holding accepted payload, head byte shown without read latency
module rx_payload_buffer
  import udp_ep_pkg::*;
(
  input  logic  clk_axi,
  input  logic  rst_axi,
  udp_byte_stream_if.sink in_stream,
  input  logic  i_rd_en,
  output byte_t o_rd_data,
  output logic  o_rd_empty,
  output logic  o_full
);

  byte_t                mem [RX_BUF_DEPTH];
  logic [RX_BUF_AW:0]   wr_ptr;
  logic [RX_BUF_AW:0]   rd_ptr;
  logic                 wr_en;
  logic                 rd_en;

  // Extra pointer bit tells full from empty
  assign o_rd_empty = (wr_ptr == rd_ptr);
  assign o_full     = (wr_ptr[RX_BUF_AW] != rd_ptr[RX_BUF_AW]) &&
                      (wr_ptr[RX_BUF_AW-1:0] == rd_ptr[RX_BUF_AW-1:0]);

  assign in_stream.tready = !o_full;

  assign wr_en = in_stream.tvalid && in_stream.tready;
  assign rd_en = i_rd_en && !o_rd_empty;

  assign o_rd_data = mem[rd_ptr[RX_BUF_AW-1:0]];

  always_ff @(posedge clk_axi) begin
    if (wr_en) begin
      mem[wr_ptr[RX_BUF_AW-1:0]] <= in_stream.tdata;
    end
  end

  always_ff @(posedge clk_axi) begin
    if (rst_axi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Host reads only what is there
  a_no_pop_empty: assert property (
    @(posedge clk_axi) disable iff (rst_axi)
    i_rd_en |-> !o_rd_empty
  );

  // A byte stalled by a full buffer is still offered next cycle, so none is lost
  a_full_holds_byte: assert property (
    @(posedge clk_axi) disable iff (rst_axi)
    (in_stream.tvalid && o_full) |=> (in_stream.tvalid && $stable(in_stream.tdata))
  );

endmodule

//--- logic/udp_send_ctrl.sv
// Holds a host send request until the stack takes it and keeps the sent interrupt flag
module udp_send_ctrl
  import udp_ep_pkg::*;
(
  input  logic     clk_axi,
  input  logic     rst_axi,
  input  logic     i_send_pkt,
  input  udp_len_t i_send_length,
  input  logic     i_udp_hdr_ready,
  input  logic     i_tx_done,
  input  logic     i_clear_irq,
  output logic     o_udp_hdr_valid,
  output udp_len_t o_udp_length,
  output logic     o_pkt_sent
);

  // Stack expects length including the UDP header
  assign o_udp_length = i_send_length + UDP_HDR_BYTES;

  always_ff @(posedge clk_axi) begin
    if (rst_axi) begin
      o_udp_hdr_valid <= 1'b0;
    end else if (o_udp_hdr_valid) begin
      o_udp_hdr_valid <= !i_udp_hdr_ready;
    end else if (i_send_pkt) begin
      o_udp_hdr_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk_axi) begin
    if (rst_axi) begin
      o_pkt_sent <= 1'b0;
    end else if (i_clear_irq) begin
      o_pkt_sent <= 1'b0;
    end else if (i_tx_done) begin
      o_pkt_sent <= 1'b1;
    end
  end

  // Header length stays put while the request waits
  a_len_stable: assert property (
    @(posedge clk_axi) disable iff (rst_axi)
    (o_udp_hdr_valid && !i_udp_hdr_ready) |=> $stable(o_udp_length)
  );

endmodule

//--- logic/udp_endpoint.sv
// UDP endpoint control top level, receive filter and buffer plus send control on plain ports
module udp_endpoint
  import udp_ep_pkg::*;
(
  input  logic      clk_axi,
  input  logic      rst_axi,
  // Received header from the stack
  input  logic      i_hdr_valid,
  input  mac_addr_t i_src_mac,
  input  ip_addr_t  i_src_ip,
  input  ip_proto_t i_protocol,
  input  udp_port_t i_src_port,
  input  udp_port_t i_dst_port,
  input  udp_len_t  i_udp_length,
  // Filter configuration
  input  logic      i_filter_en,
  input  udp_port_t i_filter_port,
  input  ip_addr_t  i_filter_ip,
  // Received payload
  input  byte_t     i_pl_tdata,
  input  logic      i_pl_tvalid,
  input  logic      i_pl_tlast,
  output logic      o_pl_tready,
  // Latched header of the last accepted frame
  output mac_addr_t o_recv_mac,
  output ip_addr_t  o_recv_ip,
  output udp_port_t o_recv_src_port,
  output udp_port_t o_recv_dst_port,
  output udp_len_t  o_recv_length,
  // Buffer read side
  input  logic      i_rd_en,
  output byte_t     o_rd_data,
  output logic      o_rd_empty,
  output logic      o_rx_full,
  // Send request
  input  logic      i_send_pkt,
  input  udp_len_t  i_send_length,
  input  logic      i_udp_hdr_ready,
  input  logic      i_tx_done,
  output logic      o_udp_hdr_valid,
  output udp_len_t  o_udp_length,
  // Interrupts
  input  logic      i_clear_irq,
  output logic      o_pkt_recv,
  output logic      o_pkt_sent
);

  udp_byte_stream_if rx_stream ();

  udp_rx_filter u_udp_rx_filter (
    .clk_axi         (clk_axi),
    .rst_axi         (rst_axi),
    .i_hdr_valid     (i_hdr_valid),
    .i_src_mac       (i_src_mac),
    .i_src_ip        (i_src_ip),
    .i_protocol      (i_protocol),
    .i_src_port      (i_src_port),
    .i_dst_port      (i_dst_port),
    .i_udp_length    (i_udp_length),
    .i_filter_en     (i_filter_en),
    .i_filter_port   (i_filter_port),
    .i_filter_ip     (i_filter_ip),
    .i_pl_tdata      (i_pl_tdata),
    .i_pl_tvalid     (i_pl_tvalid),
    .i_pl_tlast      (i_pl_tlast),
    .o_pl_tready     (o_pl_tready),
    .out_stream      (rx_stream.src),
    .i_clear_irq     (i_clear_irq),
    .o_recv_mac      (o_recv_mac),
    .o_recv_ip       (o_recv_ip),
    .o_recv_src_port (o_recv_src_port),
    .o_recv_dst_port (o_recv_dst_port),
    .o_recv_length   (o_recv_length),
    .o_pkt_recv      (o_pkt_recv)
  );

  rx_payload_buffer u_rx_payload_buffer (
    .clk_axi    (clk_axi),
    .rst_axi    (rst_axi),
    .in_stream  (rx_stream.sink),
    .i_rd_en    (i_rd_en),
    .o_rd_data  (o_rd_data),
    .o_rd_empty (o_rd_empty),
    .o_full     (o_rx_full)
  );

  udp_send_ctrl u_udp_send_ctrl (
    .clk_axi         (clk_axi),
    .rst_axi         (rst_axi),
    .i_send_pkt      (i_send_pkt),
    .i_send_length   (i_send_length),
    .i_udp_hdr_ready (i_udp_hdr_ready),
    .i_tx_done       (i_tx_done),
    .i_clear_irq     (i_clear_irq),
    .o_udp_hdr_valid (o_udp_hdr_valid),
    .o_udp_length    (o_udp_length),
    .o_pkt_sent      (o_pkt_sent)
  );

endmodule

//--- dv/udp_endpoint_tb.sv
// Table-driven testbench for the UDP endpoint, run each frame row through filter, buffer and send
module udp_endpoint_tb
  import udp_ep_pkg::*;
();

  typedef struct packed {
    logic      filter_en;
    udp_port_t filter_port;
    ip_addr_t  filter_ip;
    udp_port_t dst_port;
    ip_addr_t  src_ip;
    ip_proto_t protocol;
    udp_len_t  pl_len;
    udp_len_t  send_len;
    logic      exp_accept;
  } row_t;

  localparam int NUM_ROWS       = 8;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 200;

  logic      clk_axi, rst_axi;
  logic      i_hdr_valid, i_filter_en, i_pl_tvalid, i_pl_tlast, o_pl_tready;
  mac_addr_t i_src_mac, o_recv_mac;
  ip_addr_t  i_src_ip, i_filter_ip, o_recv_ip;
  ip_proto_t i_protocol;
  udp_port_t i_src_port, i_dst_port, i_filter_port, o_recv_src_port, o_recv_dst_port;
  udp_len_t  i_udp_length, o_recv_length, i_send_length, o_udp_length;
  byte_t     i_pl_tdata, o_rd_data;
  logic      i_rd_en, o_rd_empty, o_rx_full;
  logic      i_send_pkt, i_udp_hdr_ready, i_tx_done, o_udp_hdr_valid;
  logic      i_clear_irq, o_pkt_recv, o_pkt_sent;

  row_t      rows [NUM_ROWS];
  byte_t     payload_q [$];
  int        error_count = 0;
  int        cycle_count = 0;
  int        seed_val;
  mac_addr_t exp_mac = '0;
  ip_addr_t  exp_ip = '0;
  udp_port_t exp_sport = '0;
  udp_port_t exp_dport = '0;
  udp_len_t  exp_len = '0;

  udp_endpoint DUT (.*);

  initial begin
    clk_axi = 1'b0;
    forever #10 clk_axi = ~clk_axi;
  end

  always @(posedge clk_axi) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Run timed out after %0d cycles without finishing the table", cycle_count);
    $display("Test FAILED");
    $finish;
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    error_count++;
  endtask

  task automatic fill_row(input int idx, input logic en, input udp_port_t fport,
                          input ip_addr_t fip, input udp_port_t dport, input ip_addr_t sip,
                          input ip_proto_t proto, input udp_len_t len, input udp_len_t slen,
                          input logic acc);
    rows[idx].filter_en   = en;
    rows[idx].filter_port = fport;
    rows[idx].filter_ip   = fip;
    rows[idx].dst_port    = dport;
    rows[idx].src_ip      = sip;
    rows[idx].protocol    = proto;
    rows[idx].pl_len      = len;
    rows[idx].send_len    = slen;
    rows[idx].exp_accept  = acc;
  endtask

  task automatic send_header(input int idx, input row_t r);
    i_filter_en   = r.filter_en;
    i_filter_port = r.filter_port;
    i_filter_ip   = r.filter_ip;
    i_src_mac     = 48'h02aa_0000_0000 | idx;
    i_src_ip      = r.src_ip;
    i_protocol    = r.protocol;
    i_src_port    = 16'h4000 + idx;
    i_dst_port    = r.dst_port;
    i_udp_length  = r.pl_len + 16'd8;
    i_hdr_valid   = 1'b1;
    @(negedge clk_axi);
    i_hdr_valid = 1'b0;
    // Accepted header replaces the latched fields, payload length only
    if (r.exp_accept) begin
      exp_mac   = 48'h02aa_0000_0000 | idx;
      exp_ip    = r.src_ip;
      exp_sport = 16'h4000 + idx;
      exp_dport = r.dst_port;
      exp_len   = r.pl_len;
    end
  endtask

  task automatic check_recv_fields();
    check_value("o_recv_mac", o_recv_mac, exp_mac);
    check_value("o_recv_ip", o_recv_ip, exp_ip);
    check_value("o_recv_src_port", o_recv_src_port, exp_sport);
    check_value("o_recv_dst_port", o_recv_dst_port, exp_dport);
    check_value("o_recv_length", o_recv_length, exp_len);
  endtask

  task automatic send_payload(input row_t r);
    int    k;
    logic  ready_seen;
    byte_t b;
    for (k = 0; k < r.pl_len; k++) begin
      b           = $urandom & 8'hff;
      i_pl_tdata  = b;
      i_pl_tvalid = 1'b1;
      i_pl_tlast  = (k == r.pl_len - 1);
      if (r.exp_accept) payload_q.push_back(b);
      ready_seen = 1'b0;
      // Byte moves on the next rising edge only if ready is high now
      while (!ready_seen) begin
        ready_seen = o_pl_tready;
        if (!r.exp_accept && !ready_seen) begin
          report_error("payload of a dropped frame was stalled");
        end
        @(negedge clk_axi);
      end
    end
    i_pl_tvalid = 1'b0;
    i_pl_tlast  = 1'b0;
  endtask

  task automatic drain_buffer();
    int    n;
    byte_t exp_byte;
    n = 0;
    while (!o_rd_empty && n <= RX_BUF_DEPTH) begin
      if (payload_q.size() == 0) begin
        report_error("buffer returned a byte that was never sent");
      end else begin
        exp_byte = payload_q.pop_front();
        check_value("o_rd_data", o_rd_data, exp_byte);
      end
      i_rd_en = 1'b1;
      @(negedge clk_axi);
      i_rd_en = 1'b0;
      n++;
    end
    if (payload_q.size() != 0) begin
      report_error($sformatf("%0d payload bytes never came out of the buffer", payload_q.size()));
    end
    payload_q.delete();
  endtask

  task automatic clear_irqs(input logic exp_sent);
    check_value("o_pkt_sent", o_pkt_sent, exp_sent);
    i_clear_irq = 1'b1;
    @(negedge clk_axi);
    i_clear_irq = 1'b0;
    check_value("o_pkt_recv", o_pkt_recv, 1'b0);
    check_value("o_pkt_sent", o_pkt_sent, 1'b0);
  endtask

  task automatic run_send(input udp_len_t slen);
    int delay;
    delay         = $urandom % 6;
    i_send_length = slen;
    i_send_pkt    = 1'b1;
    @(negedge clk_axi);
    i_send_pkt = 1'b0;
    check_value("o_udp_hdr_valid", o_udp_hdr_valid, 1'b1);
    check_value("o_udp_length", o_udp_length, slen + 16'd8);
    repeat (delay) begin
      @(negedge clk_axi);
      check_value("o_udp_hdr_valid", o_udp_hdr_valid, 1'b1);
      check_value("o_udp_length", o_udp_length, slen + 16'd8);
    end
    i_udp_hdr_ready = 1'b1;
    @(negedge clk_axi);
    i_udp_hdr_ready = 1'b0;
    check_value("o_udp_hdr_valid", o_udp_hdr_valid, 1'b0);
    i_tx_done = 1'b1;
    @(negedge clk_axi);
    i_tx_done = 1'b0;
    check_value("o_pkt_sent", o_pkt_sent, 1'b1);
    check_value("o_pkt_recv", o_pkt_recv, 1'b0);
  endtask

  initial begin
    seed_val = $urandom(96);
    rst_axi = 1'b1;
    {i_hdr_valid, i_filter_en, i_pl_tvalid, i_pl_tlast, i_rd_en} = '0;
    {i_send_pkt, i_udp_hdr_ready, i_tx_done, i_clear_irq} = '0;
    {i_src_mac, i_src_ip, i_protocol, i_src_port, i_dst_port, i_udp_length} = '0;
    {i_filter_port, i_filter_ip, i_pl_tdata, i_send_length} = '0;

    // Match, wrong port, wrong IP, wrong protocol, filter off, full buffer, single byte
    fill_row(0, 1, 16'd5000, 32'hc0a80101, 16'd5000, 32'hc0a80101, 8'd17, 16'd4, 16'd100, 1);
    fill_row(1, 1, 16'd5000, 32'hc0a80101, 16'd5001, 32'hc0a80101, 8'd17, 16'd3, 16'd20, 0);
    fill_row(2, 1, 16'd5000, 32'hc0a80101, 16'd5000, 32'hc0a80102, 8'd17, 16'd5, 16'd0, 0);
    fill_row(3, 1, 16'd5000, 32'hc0a80101, 16'd5000, 32'hc0a80101, 8'd6, 16'd2, 16'd64, 0);
    fill_row(4, 0, 16'd5000, 32'hc0a80101, 16'd80, 32'h0a000009, 8'd6, 16'd7, 16'd1472, 1);
    fill_row(5, 1, 16'd5000, 32'hc0a80101, 16'd5000, 32'hc0a80101, 8'd17, 16'd16, 16'd9, 1);
    fill_row(6, 0, 16'd5000, 32'hc0a80101, 16'd5000, 32'hc0a80101, 8'd17, 16'd1, 16'd33, 1);
    fill_row(7, 1, 16'd1234, 32'h0a000001, 16'd1234, 32'h0a000001, 8'd17, 16'd9, 16'd512, 1);

    repeat (4) @(negedge clk_axi);
    rst_axi = 1'b0;
    check_value("o_pkt_recv", o_pkt_recv, 1'b0);
    check_value("o_pkt_sent", o_pkt_sent, 1'b0);
    check_value("o_udp_hdr_valid", o_udp_hdr_valid, 1'b0);
    check_value("o_pl_tready", o_pl_tready, 1'b0);
    check_value("o_rd_empty", o_rd_empty, 1'b1);

    for (int i = 0; i < NUM_ROWS; i++) begin
      send_header(i, rows[i]);
      check_recv_fields();
      send_payload(rows[i]);
      check_value("o_pkt_recv", o_pkt_recv, rows[i].exp_accept);
      check_value("o_rd_empty", o_rd_empty, !rows[i].exp_accept);
      check_value("o_rx_full", o_rx_full, rows[i].exp_accept && rows[i].pl_len == RX_BUF_DEPTH);
      check_recv_fields();
      drain_buffer();
      clear_irqs(i > 0);
      run_send(rows[i].send_len);
    end

    $display("Table done after %0d cycles, %0d errors", cycle_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
logic/udp_ep_pkg.sv
logic/udp_byte_stream_if.sv
logic/udp_rx_filter.sv
logic/rx_payload_buffer.sv
logic/udp_send_ctrl.sv
logic/udp_endpoint.sv
dv/udp_endpoint_tb.sv
